/* rtl/accelFabricPkg.sv */
`default_nettype none

package accelFabricPkg;

   //==========================================================================
   // tile addressing
   //==========================================================================
   typedef logic [3:0] tTileId;            // fabric address of one tile

   // one ready bit per tile
   // indexed by tile id, sampled by the sender holding a message
   typedef logic [15:0] tFabReady;

   //==========================================================================
   // fabric transaction
   //==========================================================================
   typedef enum logic [2:0] {
      fabWr      = 3'd0,                   // write one memory word
      fabRd      = 3'd1,                   // read one memory word
      fabRdRsp   = 3'd2,                   // read data back to requestor
      fabAccSum  = 3'd3,                   // start sum reduction
      fabAccXor  = 3'd4,                   // start xor reduction
      fabAccDone = 3'd5                    // reduction result
   } tFabOpcode;

   // reductions reuse the same fields
   // address is the base word, data[15:0] the word count
   typedef struct packed {
      tFabOpcode   opcode;                 // 3 bits
      tTileId      requestor;              // who sent it
      tTileId      destination;            // who gets it
      logic [15:0] address;                // word address
      logic [31:0] data;                   // payload
   } tTileTrans;                           // 59 bits total

endpackage

`default_nettype wire

/* rtl/accelCorePkg.sv */
`default_nettype none

package accelCorePkg;

   //==========================================================================
   // reduction engine types
   //==========================================================================
   typedef enum logic {
      accSum = 1'b0,                       // add mod 2^32
      accXor = 1'b1                        // bitwise xor
   } tAccOp;

   typedef enum logic [1:0] {
      engIdle  = 2'd0,                     // waiting for a command
      engRun   = 2'd1,                     // one read per cycle
      engDrain = 2'd2,                     // last word lands in accum
      engDone  = 2'd3                      // result waits for out reg
   } tEngState;

   // engine read port into local memory
   typedef struct packed {
      logic        rdEn;
      logic [15:0] address;
   } tCore2MemReq;                         // 17 bits

   // finished reduction handed to the mem wrapper
   typedef struct packed {
      logic                   valid;
      accelFabricPkg::tTileId requestor;   // destination of the reply
      logic [31:0]            result;
   } tDoneMsg;

endpackage

`default_nettype wire

/* rtl/accelCoreCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreCtrl (
   input  logic                      Clock,
   input  logic                      arstN,
   input  logic                      inFabricValidQ503H,
   input  accelFabricPkg::tTileTrans inFabricQ503H,
   input  logic                      cntLast,         // this read is the final one
   input  logic                      cntEmpty,        // zero length command
   input  logic [15:0]               cntAddr,
   output accelCorePkg::tCore2MemReq memReq,
   output logic                      cntLoad,
   output logic                      cntStep,
   output logic                      accClear,
   output logic                      accEn,
   output accelCorePkg::tAccOp       accOp,
   input  logic [31:0]               accResult,
   output accelCorePkg::tDoneMsg     doneMsg,
   input  logic                      doneTaken,       // out reg took the message
   output logic                      engBusy
);
   import accelFabricPkg::*;
   import accelCorePkg::*;

   tEngState stateQ;
   tEngState stateNxt;
   tTileId   reqIdQ;                                  // who asked for the result
   logic     redStart;

   // mem wrapper owns wr and rd
   assign redStart = inFabricValidQ503H &&
                     (inFabricQ503H.opcode inside {fabAccSum, fabAccXor});

   //==========================================================================
   // next state and strobes
   //==========================================================================
   always_comb begin
      stateNxt       = stateQ;
      cntLoad        = 1'b0;
      cntStep        = 1'b0;
      accClear       = 1'b0;
      memReq.rdEn    = 1'b0;
      memReq.address = cntAddr;                       // counter walks the block
      case (stateQ)
         engIdle: begin
            if (redStart) begin
               cntLoad  = 1'b1;                       // grab base and length
               accClear = 1'b1;
               stateNxt = cntEmpty ? engDrain : engRun;   // nothing to read
            end
         end
         engRun: begin
            memReq.rdEn = 1'b1;                       // one word per cycle
            cntStep     = 1'b1;
            if (cntLast) begin
               stateNxt = engDrain;
            end
         end
         engDrain: begin
            stateNxt = engDone;                       // last word folds here
         end
         engDone: begin
            if (doneTaken) begin
               stateNxt = engIdle;
            end
         end
         default: begin
            stateNxt = engIdle;
         end
      endcase
   end

   assign engBusy        = (stateQ != engIdle);

   assign doneMsg.valid     = (stateQ == engDone);
   assign doneMsg.requestor = reqIdQ;
   assign doneMsg.result    = accResult;              // settled after drain

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         stateQ <= engIdle;
         accEn  <= 1'b0;
      end else begin
         stateQ <= stateNxt;
         accEn  <= memReq.rdEn;                       // lines up with read data
      end
   end

   // command fields held for the whole pass
   always_ff @(posedge Clock) begin
      if (stateQ == engIdle && redStart) begin
         reqIdQ <= inFabricQ503H.requestor;
         accOp  <= (inFabricQ503H.opcode == fabAccXor) ? accXor : accSum;
      end
   end

   // arbiter must hold off while a pass is in flight
   assert property (@(posedge Clock) disable iff (!arstN)
      redStart |-> stateQ == engIdle)
      else $error("reduction command while engine busy");

endmodule

`default_nettype wire

/* rtl/accelCoreCounter.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreCounter #(
   parameter int memWords = 256
) (
   input  logic        Clock,
   input  logic        arstN,
   input  logic        cntLoad,
   input  logic        cntStep,
   input  logic [15:0] baseAddr,
   input  logic [15:0] count,
   output logic [15:0] cntAddr,
   output logic        cntEmpty,
   output logic        cntLast
);
   localparam int addrW = $clog2(memWords);           // word index width

   logic [addrW-1:0] addrQ;                           // wraps at memWords
   logic [15:0]      remainQ;                         // reads still to issue

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         addrQ   <= '0;
         remainQ <= '0;
      end else if (cntLoad) begin
         addrQ   <= baseAddr[addrW-1:0];              // upper bits ignored
         remainQ <= count;
      end else if (cntStep) begin
         addrQ   <= addrQ + 1'b1;
         remainQ <= remainQ - 16'd1;
      end
   end

   assign cntAddr  = 16'(addrQ);
   assign cntLast  = (remainQ == 16'd1);              // final read this cycle
   assign cntEmpty = (count == 16'd0);                // checked at load

   // engine has to stop at cntLast
   assert property (@(posedge Clock) disable iff (!arstN)
      cntStep |-> remainQ != 16'd0)
      else $error("counter stepped past end of block");

endmodule

`default_nettype wire

/* rtl/accelCoreAccum.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreAccum (
   input  logic                Clock,
   input  logic                arstN,
   input  logic                accClear,
   input  logic                accEn,                 // read data valid
   input  accelCorePkg::tAccOp accOp,
   input  logic [31:0]         memRdDataQ504H,
   output logic [31:0]         accResult
);
   import accelCorePkg::*;

   logic [31:0] foldNxt;

   always_comb begin
      case (accOp)
         accXor:  foldNxt = accResult ^ memRdDataQ504H;
         default: foldNxt = accResult + memRdDataQ504H;   // wraps mod 2^32
      endcase
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         accResult <= '0;
      end else if (accClear) begin
         accResult <= '0;                             // zero for both ops
      end else if (accEn) begin
         accResult <= foldNxt;
      end
   end

endmodule

`default_nettype wire

/* rtl/accelCoreMemWrap.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreMemWrap #(
   parameter int memWords = 256
) (
   input  logic                      Clock,
   input  logic                      arstN,
   input  accelFabricPkg::tTileId    localTileId,
   input  logic                      inFabricValidQ503H,
   input  accelFabricPkg::tTileTrans inFabricQ503H,
   input  accelCorePkg::tCore2MemReq memReq,
   output logic [31:0]               memRdDataQ504H,
   input  accelCorePkg::tDoneMsg     doneMsg,
   output logic                      doneTaken,
   input  logic                      engBusy,
   output logic                      miniCoreReady,
   output logic                      outFabricValidQ505H,
   output accelFabricPkg::tTileTrans outFabricQ505H,
   input  accelFabricPkg::tFabReady  fabReady
);
   import accelFabricPkg::*;

   localparam int addrW = $clog2(memWords);

   logic [31:0] memQ [memWords];                      // local word memory
   logic [15:0] memAddr;
   logic        memWrEn;
   logic        memRdEn;
   logic        fabRdEn;
   logic        rdPendQ504H;                          // fabric read in flight
   tTileId      rdReqIdQ504H;
   logic [15:0] rdAddrQ504H;
   logic        outLeave;

   //==========================================================================
   // memory port
   //==========================================================================
   assign memWrEn = inFabricValidQ503H && (inFabricQ503H.opcode == fabWr);
   assign fabRdEn = inFabricValidQ503H && (inFabricQ503H.opcode == fabRd);
   assign memRdEn = fabRdEn || memReq.rdEn;
   // engine and fabric never overlap, ready is low during a pass
   assign memAddr = memReq.rdEn ? memReq.address : inFabricQ503H.address;

   always_ff @(posedge Clock) begin
      if (memWrEn) begin
         memQ[memAddr[addrW-1:0]] <= inFabricQ503H.data;
      end
      if (memRdEn) begin
         memRdDataQ504H <= memQ[memAddr[addrW-1:0]];  // one cycle latency
      end
   end

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         rdPendQ504H <= 1'b0;
      end else begin
         rdPendQ504H <= fabRdEn;
      end
   end

   // reply fields for the fabric read
   always_ff @(posedge Clock) begin
      if (fabRdEn) begin
         rdReqIdQ504H <= inFabricQ503H.requestor;
         rdAddrQ504H  <= inFabricQ503H.address;
      end
   end

   //==========================================================================
   // outgoing register
   //==========================================================================
   assign outLeave  = outFabricValidQ505H && fabReady[outFabricQ505H.destination];
   assign doneTaken = doneMsg.valid && !outFabricValidQ505H && !rdPendQ504H;

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         outFabricValidQ505H <= 1'b0;
      end else if (rdPendQ504H || doneTaken) begin
         outFabricValidQ505H <= 1'b1;
      end else if (outLeave) begin
         outFabricValidQ505H <= 1'b0;                 // left on this edge
      end
   end

   always_ff @(posedge Clock) begin
      if (rdPendQ504H) begin
         outFabricQ505H.opcode      <= fabRdRsp;
         outFabricQ505H.requestor   <= localTileId;
         outFabricQ505H.destination <= rdReqIdQ504H;  // back to the reader
         outFabricQ505H.address     <= rdAddrQ504H;
         outFabricQ505H.data        <= memRdDataQ504H;
      end else if (doneTaken) begin
         outFabricQ505H.opcode      <= fabAccDone;
         outFabricQ505H.requestor   <= localTileId;
         outFabricQ505H.destination <= doneMsg.requestor;
         outFabricQ505H.address     <= 16'd0;         // no address for results
         outFabricQ505H.data        <= doneMsg.result;
      end
   end

   // low while anything is owed to the fabric
   assign miniCoreReady = !engBusy && !outFabricValidQ505H && !rdPendQ504H;

   assert property (@(posedge Clock) disable iff (!arstN)
      inFabricValidQ503H |-> miniCoreReady)
      else $error("fabric request while tile not ready");

   // a blocked message must not change under the receiver
   assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H && !outLeave |=> outFabricValidQ505H && $stable(outFabricQ505H))
      else $error("outgoing message changed while held");

endmodule

`default_nettype wire

/* rtl/accelCoreTop.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreTop #(
   parameter int memWords = 256                       // words of local memory
) (
   input  logic                      Clock,
   input  logic                      arstN,
   input  accelFabricPkg::tTileId    localTileId,
   //==========================================================================
   //      fabric interface
   //==========================================================================
   input  logic                      inFabricValidQ503H,
   input  accelFabricPkg::tTileTrans inFabricQ503H,
   output logic                      miniCoreReady,   // to arbiter
   output logic                      outFabricValidQ505H,
   output accelFabricPkg::tTileTrans outFabricQ505H,
   input  accelFabricPkg::tFabReady  fabReady
);
   import accelCorePkg::*;

   tCore2MemReq memReq;                               // engine -> memory
   logic [31:0] memRdDataQ504H;                       // memory -> accum
   logic        cntLoad;
   logic        cntStep;
   logic [15:0] cntAddr;
   logic        cntEmpty;
   logic        cntLast;
   logic        accClear;
   logic        accEn;
   tAccOp       accOp;
   logic [31:0] accResult;
   tDoneMsg     doneMsg;                              // engine -> out reg
   logic        doneTaken;
   logic        engBusy;

   accelCoreCtrl accelCoreCtrl_i (
      .Clock              (Clock),
      .arstN              (arstN),
      .inFabricValidQ503H (inFabricValidQ503H),
      .inFabricQ503H      (inFabricQ503H),
      .cntLast            (cntLast),
      .cntEmpty           (cntEmpty),
      .cntAddr            (cntAddr),
      .memReq             (memReq),
      .cntLoad            (cntLoad),
      .cntStep            (cntStep),
      .accClear           (accClear),
      .accEn              (accEn),
      .accOp              (accOp),
      .accResult          (accResult),
      .doneMsg            (doneMsg),
      .doneTaken          (doneTaken),
      .engBusy            (engBusy)
   );

   accelCoreCounter #(
      .memWords (memWords)
   ) accelCoreCounter_i (
      .Clock    (Clock),
      .arstN    (arstN),
      .cntLoad  (cntLoad),
      .cntStep  (cntStep),
      .baseAddr (inFabricQ503H.address),              // base word of the block
      .count    (inFabricQ503H.data[15:0]),           // block length
      .cntAddr  (cntAddr),
      .cntEmpty (cntEmpty),
      .cntLast  (cntLast)
   );

   accelCoreAccum accelCoreAccum_i (
      .Clock          (Clock),
      .arstN          (arstN),
      .accClear       (accClear),
      .accEn          (accEn),
      .accOp          (accOp),
      .memRdDataQ504H (memRdDataQ504H),
      .accResult      (accResult)
   );

   accelCoreMemWrap #(
      .memWords (memWords)
   ) accelCoreMemWrap_i (
      .Clock               (Clock),
      .arstN               (arstN),
      .localTileId         (localTileId),
      .inFabricValidQ503H  (inFabricValidQ503H),
      .inFabricQ503H       (inFabricQ503H),
      .memReq              (memReq),
      .memRdDataQ504H      (memRdDataQ504H),
      .doneMsg             (doneMsg),
      .doneTaken           (doneTaken),
      .engBusy             (engBusy),
      .miniCoreReady       (miniCoreReady),
      .outFabricValidQ505H (outFabricValidQ505H),
      .outFabricQ505H      (outFabricQ505H),
      .fabReady            (fabReady)
   );

endmodule

`default_nettype wire

/* testbench/accelCoreClkGen.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreClkGen #(
   parameter int halfPeriod  = 10,                    // 20 ns clock
   parameter int resetCycles = 8
) (
   output logic Clock,
   output logic arstN
);

   initial begin
      Clock = 1'b0;
      forever #(halfPeriod) Clock = ~Clock;
   end

   initial begin
      arstN = 1'b0;                                   // held from time zero
      repeat (resetCycles) @(posedge Clock);
      arstN <= 1'b1;                                  // release on an edge
   end

endmodule

`default_nettype wire

/* testbench/accelCoreTopTb.sv */
`timescale 1ns/100ps
`default_nettype none

module accelCoreTopTb;
   import accelFabricPkg::*;

   localparam int memWords = 64;                      // small, so wraps come quickly

   logic        Clock;
   logic        arstN;
   tTileId      localTileId;
   logic        inFabricValidQ503H;
   tTileTrans   inFabricQ503H;
   logic        miniCoreReady;
   logic        outFabricValidQ505H;
   tTileTrans   outFabricQ505H;
   tFabReady    fabReady = '1;
   logic [31:0] modelMem [memWords];                  // reference memory
   tTileTrans   expMsg = '0;                          // next message expected out
   logic [31:0] dataLfsrQ = 32'h1cb1;
   logic [31:0] readyLfsrQ = 32'h1cb1;
   logic        readyRandom = 1'b0;
   logic        holdEn = 1'b0;                        // pin one ready bit low
   tTileId      holdId = '0;
   logic        rdAge1Q;
   logic        rdAge2Q;                              // read accepted two edges ago
   logic        redPendQ;                             // reduction in flight
   int          checkErrors = 0;
   int          timeoutErrors = 0;

   accelCoreClkGen accelCoreClkGen_i (
      .Clock (Clock),
      .arstN (arstN)
   );

   accelCoreTop #(
      .memWords (memWords)
   ) accelCoreTop_i (
      .Clock               (Clock),
      .arstN               (arstN),
      .localTileId         (localTileId),
      .inFabricValidQ503H  (inFabricValidQ503H),
      .inFabricQ503H       (inFabricQ503H),
      .miniCoreReady       (miniCoreReady),
      .outFabricValidQ505H (outFabricValidQ505H),
      .outFabricQ505H      (outFabricQ505H),
      .fabReady            (fabReady)
   );

   //==========================================================================
   // random source and reporting
   //==========================================================================
   function automatic logic [31:0] galoisStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);   // x^32+x^30+x^26+x^25+1
   endfunction

   task automatic drawBits(input int n, output logic [31:0] val);
      int i;
      val = '0;
      for (i = 0; i < n; i++) begin
         val[i]    = dataLfsrQ[0];
         dataLfsrQ = galoisStep(dataLfsrQ);
      end
   endtask

   task automatic reportMismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
      checkErrors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
   endtask

   task automatic reportFault(input string what);
      checkErrors++;
      $display("error: %s", what);
   endtask

   // per-tile ready pattern with one lfsr step per bit
   always @(posedge Clock) begin : readyDrive
      logic [15:0] bits;
      int          i;
      bits = '1;
      if (readyRandom) begin
         for (i = 0; i < 16; i++) begin
            bits[i]    = readyLfsrQ[0];
            readyLfsrQ = galoisStep(readyLfsrQ);
         end
      end
      if (holdEn) begin
         bits[holdId] = 1'b0;                         // back-pressure on one tile
      end
      fabReady <= bits;
   end

   // request history for the timing checks
   always @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         rdAge1Q  <= 1'b0;
         rdAge2Q  <= 1'b0;
         redPendQ <= 1'b0;
      end else begin
         rdAge1Q <= inFabricValidQ503H && (inFabricQ503H.opcode == fabRd);
         rdAge2Q <= rdAge1Q;
         if (inFabricValidQ503H && (inFabricQ503H.opcode inside {fabAccSum, fabAccXor})) begin
            redPendQ <= 1'b1;
         end else if (outFabricValidQ505H && fabReady[expMsg.destination] &&
                      expMsg.opcode == fabAccDone) begin
            redPendQ <= 1'b0;                         // result left the tile
         end
      end
   end

   //==========================================================================
   // checks
   //==========================================================================
   aResetOut: assert property (@(posedge Clock) $rose(arstN) |->
      miniCoreReady && !outFabricValidQ505H)
      else reportFault("tile not idle and ready after reset");

   aRdTiming: assert property (@(posedge Clock) disable iff (!arstN)
      rdAge2Q |-> outFabricValidQ505H)
      else reportFault("read response valid missing one edge after the read");

   aOpcode: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H |-> outFabricQ505H.opcode == expMsg.opcode)
      else reportMismatch("outFabricQ505H.opcode", 64'($sampled(outFabricQ505H.opcode)),
                          64'($sampled(expMsg.opcode)));

   aRoute: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H |-> outFabricQ505H.requestor == expMsg.requestor &&
                              outFabricQ505H.destination == expMsg.destination)
      else reportMismatch("outFabricQ505H.requestor/destination",
                          64'({$sampled(outFabricQ505H.requestor),
                               $sampled(outFabricQ505H.destination)}),
                          64'({$sampled(expMsg.requestor), $sampled(expMsg.destination)}));

   aData: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H |-> outFabricQ505H.data == expMsg.data)
      else reportMismatch("outFabricQ505H.data", 64'($sampled(outFabricQ505H.data)),
                          64'($sampled(expMsg.data)));

   aAddr: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H && expMsg.opcode == fabRdRsp |->
         outFabricQ505H.address == expMsg.address)
      else reportMismatch("outFabricQ505H.address", 64'($sampled(outFabricQ505H.address)),
                          64'($sampled(expMsg.address)));

   aHold: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H && !fabReady[expMsg.destination] |=>
         outFabricValidQ505H && $stable(outFabricQ505H))
      else reportFault("outgoing message changed or dropped while its destination was busy");

   aLeave: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H && fabReady[expMsg.destination] |=> !outFabricValidQ505H)
      else reportFault("message stayed after its destination was ready");

   aBusyOut: assert property (@(posedge Clock) disable iff (!arstN)
      outFabricValidQ505H |-> !miniCoreReady)
      else reportFault("miniCoreReady high while a message is pending");

   aRedBusy: assert property (@(posedge Clock) disable iff (!arstN)
      redPendQ |-> !miniCoreReady)
      else reportFault("miniCoreReady high during a reduction");

   //==========================================================================
   // stimulus
   //==========================================================================
   task automatic waitReady();
      int n;
      n = 0;
      do begin
         @(posedge Clock);
         n++;
      end while (!miniCoreReady && n < 100);
      if (!miniCoreReady) begin
         timeoutErrors++;
         $display("timeout: tile never became ready");
      end
   endtask

   task automatic sendTrans(input tTileTrans t);
      waitReady();
      inFabricValidQ503H <= 1'b1;
      inFabricQ503H      <= t;
      @(posedge Clock);                               // accepted here
      inFabricValidQ503H <= 1'b0;
   endtask

   task automatic waitLeave(input string what);
      int   n;
      logic gone;
      n    = 0;
      gone = 1'b0;
      while (!gone && n < 400) begin
         @(posedge Clock);
         gone = outFabricValidQ505H && fabReady[expMsg.destination];
         n++;
      end
      if (!gone) begin
         timeoutErrors++;
         $display("timeout: no %s left the tile", what);
      end
   endtask

   task automatic countHeldCycles(input int want);
      int seen;
      int n;
      seen = 0;
      n    = 0;
      while (seen < want && n < 100) begin
         @(posedge Clock);
         if (outFabricValidQ505H) seen++;
         n++;
      end
      if (seen < want) begin
         timeoutErrors++;
         $display("timeout: held response never stayed pending");
      end
   endtask

   task automatic writeWord(input int addr, input logic [31:0] data);
      modelMem[addr] = data;
      sendTrans('{fabWr, 4'h1, localTileId, 16'(addr), data});
   endtask

   task automatic readWord(input int addr, input tTileId req);
      expMsg <= '{fabRdRsp, localTileId, req, 16'(addr), modelMem[addr]};
      sendTrans('{fabRd, req, localTileId, 16'(addr), 32'd0});
   endtask

   function automatic logic [31:0] foldModel(input logic isXor, input int base, input int len);
      logic [31:0] acc;
      int          i;
      acc = '0;
      for (i = 0; i < len; i++) begin
         if (isXor) acc = acc ^ modelMem[(base + i) % memWords];
         else       acc = acc + modelMem[(base + i) % memWords];
      end
      return acc;
   endfunction

   task automatic runReduction(input logic isXor, input int base, input int len);
      logic [31:0] r;
      tTileId      req;
      tFabOpcode   op;
      drawBits(4, r);
      req = r[3:0];
      if (isXor) begin
         op = fabAccXor;
      end else begin
         op = fabAccSum;
      end
      expMsg <= '{fabAccDone, localTileId, req, 16'd0, foldModel(isXor, base, len)};
      sendTrans('{op, req, localTileId, 16'(base), 32'(len)});
      waitLeave("reduction result");
   endtask

   initial begin
      int          a;
      int          k;
      logic [31:0] w;
      logic [31:0] r;
      inFabricValidQ503H = 1'b0;
      inFabricQ503H      = '0;
      localTileId        = 4'h5;
      k = 0;
      while (arstN !== 1'b1 && k < 50) begin
         @(posedge Clock);
         k++;
      end
      if (arstN !== 1'b1) begin
         timeoutErrors++;
         $display("timeout: reset was never released");
      end
      for (a = 0; a < memWords; a++) begin          // whole memory gets random data
         drawBits(32, w);
         writeWord(a, w);
      end
      readyRandom <= 1'b1;
      for (k = 0; k < 8; k++) begin                 // overwrite then read back
         drawBits($clog2(memWords), r);
         a = int'(r);
         drawBits(32, w);
         writeWord(a, w);
         drawBits(32, w);
         writeWord(a, w);
         drawBits(4, r);
         readWord(a, r[3:0]);
         waitLeave("read response");
      end
      holdId <= 4'h9;
      holdEn <= 1'b1;
      readWord(17, 4'h9);
      countHeldCycles(12);
      holdEn <= 1'b0;
      waitLeave("held read response");
      runReduction(1'b0, 10, 8);
      runReduction(1'b0, 3, 0);
      runReduction(1'b0, 60, 9);                    // wraps past the top
      runReduction(1'b0, 0, memWords);
      runReduction(1'b1, 10, 8);
      runReduction(1'b1, 3, 0);
      runReduction(1'b1, 58, 12);
      repeat (4) @(posedge Clock);
      $display("errors: %0d check, %0d timeout", checkErrors, timeoutErrors);
      if (checkErrors == 0 && timeoutErrors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* accelCoreTop.f */
rtl/accelFabricPkg.sv
rtl/accelCorePkg.sv
rtl/accelCoreCtrl.sv
rtl/accelCoreCounter.sv
rtl/accelCoreAccum.sv
rtl/accelCoreMemWrap.sv
rtl/accelCoreTop.sv
testbench/accelCoreClkGen.sv
testbench/accelCoreTopTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module accelCoreTopTb -f accelCoreTop.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
